// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_bnn_out_stage \
    -f sources.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "Test passed" &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }

// File: sources.f
src/bnn_pkg.sv
src/vote_counter.sv
src/sign_bank.sv
src/dst_buf.sv
src/bnn_out_stage.sv
tb/tb_bnn_out_stage.sv

// File: src/bnn_out_stage.sv
`timescale 1ns/1ps

// output stage, two sign banks feeding one destination buffer
module bnn_out_stage #(
    parameter int unsigned LANES = bnn_pkg::lanes,
    parameter int unsigned CNT_W = bnn_pkg::cnt_w
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  bnn_pkg::beat_t             in_beat,
    output logic [1:0]                 bank_ready,
    output logic [bnn_pkg::word_w-1:0] out_word,
    output logic                       out_req,
    input  logic                       out_ack
);

    // bank 0 is the lower half, bank 1 the upper
    bnn_pkg::sign_vec_t lo_signs;
    bnn_pkg::sign_vec_t hi_signs;
    logic               lo_captured;
    logic               hi_captured;
    logic               consume;

    //////////////////////////////////////////////////////////////
    // banks
    //////////////////////////////////////////////////////////////

    // same beat to both, each filters on its own index
    sign_bank #(
        .BANK_ID (0),
        .LANES   (LANES),
        .CNT_W   (CNT_W)
    ) bank0_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .beat     (in_beat),
        .consume  (consume),
        .ready    (bank_ready[0]),
        .captured (lo_captured),
        .signs    (lo_signs)
    );

    sign_bank #(
        .BANK_ID (1),
        .LANES   (LANES),
        .CNT_W   (CNT_W)
    ) bank1_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .beat     (in_beat),
        .consume  (consume),
        .ready    (bank_ready[1]),
        .captured (hi_captured),
        .signs    (hi_signs)
    );

    //////////////////////////////////////////////////////////////
    // destination buffer
    //////////////////////////////////////////////////////////////

    dst_buf dst_buf_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .lo_signs    (lo_signs),
        .lo_captured (lo_captured),
        .hi_signs    (hi_signs),
        .hi_captured (hi_captured),
        .consume     (consume),
        .out_word    (out_word),
        .out_req     (out_req),
        .out_ack     (out_ack)
    );

endmodule

// File: src/bnn_pkg.sv
package bnn_pkg;

    //////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////

    // result bits per upstream beat, default lane count
    localparam int unsigned lanes = 32;

    // default counter width, windows up to 127 beats
    localparam int unsigned cnt_w = 8;

    // output word carries both banks
    localparam int unsigned word_w = 2 * lanes;

    //////////////////////////////////////////////////////////////
    // upstream beat
    //////////////////////////////////////////////////////////////

    // one beat from the compute cores, 35 bits
    typedef struct packed {
        logic             valid;
        logic             bank;   // 0 or 1
        logic             last;   // final beat of the window
        logic [lanes-1:0] bits;   // one result bit per lane
    } beat_t;

    // captured lane signs of one bank
    typedef logic [lanes-1:0] sign_vec_t;

    //////////////////////////////////////////////////////////////
    // output word
    //////////////////////////////////////////////////////////////

    // bank 1 sits in the upper half
    typedef struct packed {
        sign_vec_t hi;
        sign_vec_t lo;
    } out_halves_t;

    // written per half, sent out as one raw word
    typedef union packed {
        logic [word_w-1:0] raw;
        out_halves_t       halves;
    } out_word_u;

endpackage

// File: src/dst_buf.sv
`timescale 1ns/1ps

// joins both bank results into one word, four-phase req/ack out
module dst_buf (
    input  logic                       clk,
    input  logic                       rst_n,
    input  bnn_pkg::sign_vec_t         lo_signs,
    input  logic                       lo_captured,
    input  bnn_pkg::sign_vec_t         hi_signs,
    input  logic                       hi_captured,
    output logic                       consume,
    output logic [bnn_pkg::word_w-1:0] out_word,
    output logic                       out_req,
    input  logic                       out_ack
);

    //////////////////////////////////////////////////////////////
    // handshake FSM
    //////////////////////////////////////////////////////////////

    // idle means the buffer is empty
    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait_ack_lo
    } state_t;

    state_t state_q;
    logic   load;

    // both halves ready and nothing in flight
    assign load = (state_q == st_idle) && lo_captured && hi_captured;

    // banks see this at the load edge and reopen
    assign consume = load;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (load) begin
                        state_q <= st_req;
                    end
                end
                // drop req once ack is seen
                st_req: begin
                    if (out_ack) begin
                        state_q <= st_wait_ack_lo;
                    end
                end
                // sink must release ack before the next word
                st_wait_ack_lo: begin
                    if (!out_ack) begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // req comes straight off the state register
    assign out_req = (state_q == st_req);

    //////////////////////////////////////////////////////////////
    // output word
    //////////////////////////////////////////////////////////////

    bnn_pkg::out_word_u word_q;

    // halves written together, held until the next load
    always_ff @(posedge clk) begin
        if (load) begin
            word_q.halves.hi <= hi_signs;
            word_q.halves.lo <= lo_signs;
        end
    end

    assign out_word = word_q.raw;

endmodule

// File: src/sign_bank.sv
`timescale 1ns/1ps

// one bank of lane counters plus its result flag
module sign_bank #(
    parameter int unsigned BANK_ID = 0,
    parameter int unsigned LANES   = bnn_pkg::lanes,
    parameter int unsigned CNT_W   = bnn_pkg::cnt_w
) (
    input  logic               clk,
    input  logic               rst_n,
    input  bnn_pkg::beat_t     beat,
    input  logic               consume,
    output logic               ready,
    output logic               captured,
    output bnn_pkg::sign_vec_t signs
);

    //////////////////////////////////////////////////////////////
    // beat acceptance
    //////////////////////////////////////////////////////////////

    logic accept;
    logic accept_last;

    // only beats tagged for this bank, and only while open
    assign accept      = beat.valid && (beat.bank == 1'(BANK_ID)) && ready;
    assign accept_last = accept && beat.last;

    //////////////////////////////////////////////////////////////
    // result flag
    //////////////////////////////////////////////////////////////

    logic captured_q;

    // set by the closing beat, cleared when the buffer takes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            captured_q <= 1'b0;
        end else if (consume) begin
            captured_q <= 1'b0;
        end else if (accept_last) begin
            captured_q <= 1'b1;
        end
    end

    assign captured = captured_q;

    // bank stays closed while its result is held
    assign ready = ~captured_q;

    //////////////////////////////////////////////////////////////
    // lane counters
    //////////////////////////////////////////////////////////////

    logic [LANES-1:0] lane_signs;

    // counters hold their sign until the next closing beat,
    // so the vector is stable while captured is high
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        vote_counter #(
            .CNT_W (CNT_W)
        ) vote_counter_i (
            .clk    (clk),
            .rst_n  (rst_n),
            .en     (accept),
            .bit_in (beat.bits[i]),
            .last   (beat.last),
            .sign   (lane_signs[i])
        );
    end

    // narrower banks zero fill the upper lanes
    assign signs = bnn_pkg::sign_vec_t'(lane_signs);

endmodule

// File: src/vote_counter.sv
`timescale 1ns/1ps

// majority vote for one lane over a window of beats
module vote_counter #(
    parameter int unsigned CNT_W = bnn_pkg::cnt_w
) (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic bit_in,
    input  logic last,
    output logic sign
);

    // running count, ones minus zeros
    logic signed [CNT_W-1:0] count_q;
    logic signed [CNT_W-1:0] count_nxt;

    // +1 for a one, -1 for a zero
    always_comb begin
        if (bit_in) begin
            count_nxt = count_q + CNT_W'(1);
        end else begin
            count_nxt = count_q - CNT_W'(1);
        end
    end

    // count restarts from zero after each window
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (en) begin
            if (last) begin
                count_q <= '0;
            end else begin
                count_q <= count_nxt;
            end
        end
    end

    // sign of the final count, zero counts as positive
    always_ff @(posedge clk) begin
        if (en && last) begin
            sign <= ~count_nxt[CNT_W-1];
        end
    end

endmodule

// File: tb/tb_bnn_out_stage.sv
`timescale 1ns/1ps

module tb_bnn_out_stage;

    //////////////////////////////////////////////////////////////
    // DUT signals and run bookkeeping
    //////////////////////////////////////////////////////////////

    // six tests, up to 40 windows each, one with a stalled sink
    localparam int max_cycles = 20000;

    logic                       clk;
    logic                       rst_n;
    bnn_pkg::beat_t             in_beat;
    logic [1:0]                 bank_ready;
    logic [bnn_pkg::word_w-1:0] out_word;
    logic                       out_req;
    logic                       out_ack;

    int errors      = 0;
    int test_errors = 0;
    int tests_ok    = 0;
    int tests_bad   = 0;
    int words_tx    = 0;
    int words_rx    = 0;
    int cycles      = 0;

    // sink timing, cycles from req to ack and from req low to ack low
    int unsigned ack_min;
    int unsigned ack_max;
    int unsigned rel_min;
    int unsigned rel_max;

    bnn_out_stage #(
        .LANES (bnn_pkg::lanes),
        .CNT_W (bnn_pkg::cnt_w)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_beat    (in_beat),
        .bank_ready (bank_ready),
        .out_word   (out_word),
        .out_req    (out_req),
        .out_ack    (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////

    int                        model_cnt [2][bnn_pkg::lanes];
    logic [bnn_pkg::lanes-1:0] model_sign [2];
    logic [1:0]                model_cap;
    // 0 empty, 1 req out, 2 waiting for ack low
    logic [1:0]                model_phase;
    logic [bnn_pkg::word_w-1:0] exp_word;
    logic                      load_now;
    logic                      close_now;

    // close_now marks the later last beat with the buffer free after it
    always_comb begin
        load_now  = (model_phase == 2'd0) && (model_cap == 2'b11);
        close_now = in_beat.valid && in_beat.last && !model_cap[in_beat.bank]
                    && model_cap[!in_beat.bank]
                    && ((model_phase == 2'd0) || (model_phase == 2'd2 && !out_ack));
    end

    always @(posedge clk) begin : model
        int d;
        if (!rst_n) begin
            model_cap   <= '0;
            model_phase <= 2'd0;
            for (int i = 0; i < bnn_pkg::lanes; i++) begin
                model_cnt[0][i] <= 0;
                model_cnt[1][i] <= 0;
            end
        end else begin
            // a taken beat moves every lane of its bank, tie counts as 1
            if (in_beat.valid && !model_cap[in_beat.bank]) begin
                for (int i = 0; i < bnn_pkg::lanes; i++) begin
                    d = in_beat.bits[i] ? 1 : -1;
                    if (in_beat.last) begin
                        model_sign[in_beat.bank][i] <= (model_cnt[in_beat.bank][i] + d >= 0);
                        model_cnt[in_beat.bank][i]  <= 0;
                    end else begin
                        model_cnt[in_beat.bank][i] <= model_cnt[in_beat.bank][i] + d;
                    end
                end
                if (in_beat.last) begin
                    model_cap[in_beat.bank] <= 1'b1;
                end
            end
            // bank 1 goes on top
            if (load_now) begin
                exp_word    <= {model_sign[1], model_sign[0]};
                model_cap   <= '0;
                model_phase <= 2'd1;
            end else if (model_phase == 2'd1 && out_ack) begin
                model_phase <= 2'd2;
            end else if (model_phase == 2'd2 && !out_ack) begin
                model_phase <= 2'd0;
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////

    a_word: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> (out_word == exp_word))
        else begin
            $display("[FAIL] %0t out_word expected %h got %h", $time,
                     $sampled(exp_word), $sampled(out_word));
            errors++;
        end

    a_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_req && $past(out_req)) |-> $stable(out_word))
        else begin
            $display("[FAIL] %0t out_word changed while out_req was high", $time);
            errors++;
        end

    // later last beat at edge k, req seen high at edge k+2
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(close_now, 2) |-> $rose(out_req))
        else begin
            $display("[FAIL] %0t out_req expected 1 got %0d", $time, $sampled(out_req));
            errors++;
        end

    a_origin: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> $past(load_now))
        else begin
            $display("%0t out_req rose without both banks holding a result", $time);
            errors++;
        end

    a_req_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> !out_ack)
        else begin
            $display("%0t out_req rose while out_ack was still high", $time);
            errors++;
        end

    a_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_req) |-> $past(out_ack))
        else begin
            $display("%0t out_req dropped before out_ack was seen", $time);
            errors++;
        end

    a_src: assert property (@(posedge clk) disable iff (!rst_n)
        in_beat.valid |-> bank_ready[in_beat.bank])
        else begin
            $display("%0t valid beat sent to a bank whose ready bit was low", $time);
            errors++;
        end

    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        bank_ready == ~model_cap)
        else begin
            $display("[FAIL] %0t bank_ready expected %b got %b", $time,
                     ~$sampled(model_cap), $sampled(bank_ready));
            errors++;
        end

    //////////////////////////////////////////////////////////////
    // sink and watchdog
    //////////////////////////////////////////////////////////////

    // values read right after an edge are the ones sampled at it
    initial begin : sink
        int unsigned d;
        out_ack <= 1'b0;
        forever begin
            @(posedge clk);
            if (out_req) begin
                d = $urandom_range(ack_max, ack_min);
                repeat (d) @(posedge clk);
                out_ack <= 1'b1;
                @(posedge clk);
                while (out_req) @(posedge clk);
                d = $urandom_range(rel_max, rel_min);
                repeat (d) @(posedge clk);
                out_ack <= 1'b0;
                words_rx++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, handshake or bank ready is stuck", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////

    // waits for ready, a last beat sampled at this edge closes the bank
    task automatic drive_beat(input logic b, input logic last, input logic [31:0] bits);
        @(posedge clk);
        while (!bank_ready[b] || (in_beat.valid && in_beat.last && in_beat.bank == b)) begin
            in_beat <= '0;
            @(posedge clk);
        end
        in_beat <= '{valid: 1'b1, bank: b, last: last, bits: bits};
    endtask

    // mode 0 random, 1 ones, 2 zeros, 3 alternating
    // order 0 bank 0 first, 1 bank 1 first, 2 interleaved
    task automatic send_pair(input int len0, input int len1, input int mode, input int order);
        int n0;
        int n1;
        int n;
        int len;
        logic pick;
        logic [bnn_pkg::lanes-1:0] bits;
        n0 = 0;
        n1 = 0;
        while (n0 < len0 || n1 < len1) begin
            if (order == 2 && n0 < len0 && n1 < len1) begin
                pick = 1'($urandom_range(1, 0));
            end else if (order == 1) begin
                pick = (n1 < len1);
            end else begin
                pick = (n0 >= len0);
            end
            n   = pick ? n1 : n0;
            len = pick ? len1 : len0;
            case (mode)
                1: bits = '1;
                2: bits = '0;
                3: bits = {bnn_pkg::lanes{n[0] == 1'b0}};
                default: bits = $urandom();
            endcase
            drive_beat(pick, n == len - 1, bits);
            if (pick) begin
                n1++;
            end else begin
                n0++;
            end
        end
        @(posedge clk);
        in_beat <= '0;
        words_tx++;
    endtask

    task automatic finish_test(input string name);
        while (words_rx < words_tx) @(posedge clk);
        repeat (10) @(posedge clk);
        a_count: assert (words_rx == words_tx) else begin
            $display("[FAIL] %0t words_rx expected %0d got %0d", $time, words_tx, words_rx);
            errors++;
        end
        if (errors == test_errors) begin
            tests_ok++;
            $display("test %s done, no errors", name);
        end else begin
            tests_bad++;
            $display("test %s done, %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin : main
        void'($urandom(87604));
        rst_n   <= 1'b0;
        in_beat <= '0;
        ack_min = 0;
        ack_max = 3;
        rel_min = 0;
        rel_max = 2;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // idle banks open, no request
        repeat (4) @(posedge clk);
        a_rst_ready: assert (bank_ready == 2'b11) else begin
            $display("[FAIL] %0t bank_ready expected 11 got %b", $time, bank_ready);
            errors++;
        end
        a_rst_req: assert (!out_req) else begin
            $display("[FAIL] %0t out_req expected 0 got %b", $time, out_req);
            errors++;
        end
        finish_test("reset");

        send_pair(5, 7, 1, 0);
        send_pair(4, 9, 2, 0);
        send_pair(6, 10, 3, 0);
        send_pair(2, 2, 3, 2);
        finish_test("uniform");

        for (int i = 0; i < 15; i++) begin
            send_pair($urandom_range(100, 1), $urandom_range(100, 1), 0, 0);
        end
        finish_test("random");

        for (int i = 0; i < 9; i++) begin
            send_pair($urandom_range(20, 1), $urandom_range(20, 1), 0, i % 3);
        end
        finish_test("order");

        // stalled sink, banks fill and close behind the held word
        ack_min = 30;
        ack_max = 30;
        for (int i = 0; i < 5; i++) begin
            send_pair($urandom_range(10, 2), $urandom_range(10, 2), 0, 0);
        end
        finish_test("backpressure");

        ack_min = 0;
        ack_max = 5;
        rel_max = 5;
        for (int i = 0; i < 40; i++) begin
            send_pair($urandom_range(6, 1), $urandom_range(6, 1), 0, $urandom_range(2, 0));
        end
        finish_test("handshake");

        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
